// ==== compile.f ====
+incdir+test
hdl/pipe_ctrl_pkg.sv
hdl/hazard_unit_if.sv
hdl/prv_pipeline_if.sv
hdl/hazard_unit.sv
hdl/priv_trap_unit.sv
hdl/pipe_ctrl_top.sv
test/pipe_ctrl_tb.sv

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input logic CLK,
    input logic nRST,
    hazard_unit_if.hazard_unit hazard_if,
    prv_pipeline_if.hazard prv_if
);

    // scalar hazards
    logic rs1_match, rs2_match;
    logic cannot_forward;
    logic mem_use_stall;
    logic branch_jump;
    logic dmem_access;
    logic wait_for_imem, wait_for_dmem;

    // trap related
    logic exception;
    logic intr;
    logic ex_flush_hazard;

    // vector
    logic vex_stall;
    logic stall_vsetvl; // decode held until vsetvl leaves execute

    // execute source vs memory destination, x0 never matches
    assign rs1_match = (hazard_if.rs1_e == hazard_if.rd_m) && (hazard_if.rd_m != '0);
    assign rs2_match = (hazard_if.rs2_e == hazard_if.rd_m) && (hazard_if.rd_m != '0);
    assign cannot_forward = hazard_if.dren || hazard_if.csr_read; // result only after mem
    assign mem_use_stall = hazard_if.reg_write && cannot_forward && (rs1_match || rs2_match);

    assign branch_jump = hazard_if.jump || (hazard_if.branch && hazard_if.mispredict);
    assign dmem_access = hazard_if.dren || hazard_if.dwen;

    // fetch wait only counts when the request still matters
    assign wait_for_imem = hazard_if.i_mem_busy && !hazard_if.suppress_iren;
    assign wait_for_dmem = dmem_access && hazard_if.d_mem_busy && !hazard_if.suppress_data;

    assign exception = |hazard_if.exc;
    assign intr = !exception && prv_if.intr; // exception wins over interrupt

    // interrupt waits for an in-flight data access to finish
    assign ex_flush_hazard = (intr && !wait_for_dmem)
                          || exception
                          || hazard_if.ret
                          || (hazard_if.ifence && !hazard_if.fence_stall); // refetch after fence

    // oldest valid pc goes to mepc, mem insn completes on interrupt
    always_comb begin
        if (hazard_if.valid_m && !intr)
            prv_if.epc = hazard_if.pc_m;
        else if (hazard_if.valid_e)
            prv_if.epc = hazard_if.pc_e;
        else if (hazard_if.valid_decode)
            prv_if.epc = hazard_if.pc_decode;
        else
            prv_if.epc = hazard_if.pc_f;
    end

    // forward to privilege block
    assign prv_if.exc = hazard_if.exc;
    assign prv_if.ret = hazard_if.ret;
    assign prv_if.badaddr = hazard_if.badaddr;
    assign prv_if.wb_enable = !hazard_if.if_ex_stall || hazard_if.jump || hazard_if.branch;

    assign hazard_if.insert_priv_pc = prv_if.insert_pc;
    assign hazard_if.priv_pc = prv_if.priv_pc;

    // request suppression
    assign hazard_if.suppress_iren = branch_jump || ex_flush_hazard
                                  || hazard_if.ret || prv_if.insert_pc; // flush is coming
    assign hazard_if.suppress_data = exception; // never touch a faulting location
    assign hazard_if.rollback = hazard_if.ifence && !hazard_if.fence_stall;

    // pc control
    assign hazard_if.npc_sel = branch_jump;
    assign hazard_if.pc_en = (!hazard_if.if_ex_stall && !wait_for_imem)
                          || branch_jump
                          || prv_if.insert_pc
                          || hazard_if.ret; // redirects always load the pc

    // flushes
    assign hazard_if.if_ex_flush = branch_jump || ex_flush_hazard
                                || wait_for_imem; // bubble while fetch lags
    assign hazard_if.flush_queue = ex_flush_hazard || branch_jump;
    assign hazard_if.flush_decode = hazard_if.flush_queue;

    // bubble into mem, but never while mem itself is waiting
    assign hazard_if.ex_mem_flush = (ex_flush_hazard || branch_jump
                                  || hazard_if.stall_queue || vex_stall)
                                 && !hazard_if.ex_mem_stall;

    // stalls, later stage stall implies earlier one
    assign hazard_if.ex_mem_stall = wait_for_dmem
                                 || hazard_if.fence_stall
                                 || hazard_if.serializer_stall
                                 || hazard_if.halt;

    // busy execute stalls unless a redirect kills its insn
    assign hazard_if.stall_queue = hazard_if.ex_mem_stall
                                || (hazard_if.ex_busy && !ex_flush_hazard && !branch_jump)
                                || mem_use_stall
                                || hazard_if.fence_stall
                                || vex_stall;

    assign hazard_if.vmask_calc_stall = hazard_if.ex_mem_stall
                                     || mem_use_stall
                                     || hazard_if.fence_stall
                                     || vex_stall;

    assign hazard_if.stall_decode = (hazard_if.is_queue_full && !hazard_if.flush_queue)
                                 || stall_vsetvl;
    assign hazard_if.if_ex_stall = hazard_if.stall_decode || hazard_if.fence_stall
                                || (hazard_if.vbusy && !hazard_if.flush_decode);

    // vector raw on a used source, or masked op overwriting v0
    always_comb begin
        vex_stall = 1'b0;
        if (hazard_if.vregwen) begin
            if (hazard_if.vs1_used && (hazard_if.vd == hazard_if.vs1))
                vex_stall = 1'b1;
            else if (hazard_if.vs2_used && (hazard_if.vd == hazard_if.vs2))
                vex_stall = 1'b1;
            else if (hazard_if.ex_mask_en && (hazard_if.vd == '0))
                vex_stall = 1'b1; // mask lives in v0
        end
    end

    // vsetvl serialization, flush beats vsetvl_ex beats set
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stall_vsetvl <= 1'b0;
        end else if (hazard_if.flush_decode) begin
            stall_vsetvl <= 1'b0;
        end else if (hazard_if.vsetvl_ex) begin
            stall_vsetvl <= 1'b0; // vl now known
        end else if (hazard_if.queue_wen && hazard_if.vsetvl_dec) begin
            stall_vsetvl <= 1'b1;
        end
    end

endmodule

// ==== hdl/hazard_unit_if.sv ====
`timescale 1ns/10ps

interface hazard_unit_if;

    // operand indices, execute sources vs memory destination
    pipe_ctrl_pkg::regidx_t rs1_e;
    pipe_ctrl_pkg::regidx_t rs2_e;
    pipe_ctrl_pkg::regidx_t rd_m;

    // memory stage status
    logic reg_write, dren, dwen, csr_read;
    logic i_mem_busy, d_mem_busy;

    // control flow and waits
    logic jump, branch, mispredict;
    logic ifence, fence_stall, serializer_stall, halt, ex_busy;

    // exceptions
    pipe_ctrl_pkg::exc_flags_t exc;
    pipe_ctrl_pkg::word_t badaddr;

    // pcs of each stage and their valid bits
    pipe_ctrl_pkg::word_t pc_f, pc_decode, pc_e, pc_m;
    logic valid_decode, valid_e, valid_m;

    // mret, decode queue
    logic ret, is_queue_full, queue_wen;

    // vector side
    logic vsetvl_dec, vsetvl_ex, vbusy, vregwen;
    pipe_ctrl_pkg::vregidx_t vd, vs1, vs2;
    logic vs1_used, vs2_used, ex_mask_en;

    // controls back to the pipeline
    logic pc_en, npc_sel, insert_priv_pc;
    pipe_ctrl_pkg::word_t priv_pc;
    logic if_ex_stall, stall_queue, stall_decode, ex_mem_stall, vmask_calc_stall;
    logic if_ex_flush, flush_queue, flush_decode, ex_mem_flush;
    logic suppress_iren, suppress_data, rollback;

    modport hazard_unit (
        input  rs1_e, rs2_e, rd_m, reg_write, dren, dwen, csr_read, i_mem_busy, d_mem_busy,
        input  jump, branch, mispredict, ifence, fence_stall, serializer_stall, halt, ex_busy,
        input  exc, badaddr, pc_f, pc_decode, pc_e, pc_m, valid_decode, valid_e, valid_m,
        input  ret, is_queue_full, queue_wen,
        input  vsetvl_dec, vsetvl_ex, vbusy, vregwen, vd, vs1, vs2, vs1_used, vs2_used,
        input  ex_mask_en,
        output pc_en, npc_sel, insert_priv_pc, priv_pc,
        output if_ex_stall, stall_queue, stall_decode, ex_mem_stall, vmask_calc_stall,
        output if_ex_flush, flush_queue, flush_decode, ex_mem_flush,
        output suppress_iren, suppress_data, rollback
    );

    modport pipeline (
        output rs1_e, rs2_e, rd_m, reg_write, dren, dwen, csr_read, i_mem_busy, d_mem_busy,
        output jump, branch, mispredict, ifence, fence_stall, serializer_stall, halt, ex_busy,
        output exc, badaddr, pc_f, pc_decode, pc_e, pc_m, valid_decode, valid_e, valid_m,
        output ret, is_queue_full, queue_wen,
        output vsetvl_dec, vsetvl_ex, vbusy, vregwen, vd, vs1, vs2, vs1_used, vs2_used,
        output ex_mask_en,
        input  pc_en, npc_sel, insert_priv_pc, priv_pc,
        input  if_ex_stall, stall_queue, stall_decode, ex_mem_stall, vmask_calc_stall,
        input  if_ex_flush, flush_queue, flush_decode, ex_mem_flush,
        input  suppress_iren, suppress_data, rollback
    );

endinterface

// ==== hdl/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // basic widths
    typedef logic [31:0] word_t;    // pc and address word
    typedef logic [4:0]  regidx_t;  // scalar register index
    typedef logic [4:0]  vregidx_t; // vector register index
    typedef logic [3:0]  cause_t;   // trap cause code

    // exception flags as raised by the stages, msb first
    typedef struct packed {
        logic fault_insn;   // fetch access fault
        logic mal_insn;     // misaligned fetch
        logic illegal_insn;
        logic fault_l;      // load access fault
        logic mal_l;        // misaligned load
        logic fault_s;      // store access fault
        logic mal_s;        // misaligned store
        logic breakpoint;   // ebreak
        logic env;          // ecall
    } exc_flags_t;

    // cause codes, machine-level numbering
    localparam cause_t CAUSE_MAL_INSN   = 4'd0;
    localparam cause_t CAUSE_FAULT_INSN = 4'd1;
    localparam cause_t CAUSE_ILLEGAL    = 4'd2;
    localparam cause_t CAUSE_BREAKPOINT = 4'd3;
    localparam cause_t CAUSE_MAL_L      = 4'd4;
    localparam cause_t CAUSE_FAULT_L    = 4'd5;
    localparam cause_t CAUSE_MAL_S      = 4'd6;
    localparam cause_t CAUSE_FAULT_S    = 4'd7;
    localparam cause_t CAUSE_ECALL      = 4'd11; // ecall from m-mode

    // no interrupt bit in a 4-bit cause, so interrupts get a code of their own
    localparam cause_t CAUSE_INTR = 4'd15;

    // fixed handler entry
    localparam word_t TRAP_VECTOR = 32'h0000_0200;

endpackage

// ==== hdl/pipe_ctrl_top.sv ====
`timescale 1ns/10ps

module pipe_ctrl_top (
    input  logic CLK,
    input  logic nRST,
    input  logic irq,
    // operand indices
    input  pipe_ctrl_pkg::regidx_t rs1_e,
    input  pipe_ctrl_pkg::regidx_t rs2_e,
    input  pipe_ctrl_pkg::regidx_t rd_m,
    // memory status
    input  logic reg_write, dren, dwen, csr_read, i_mem_busy, d_mem_busy,
    // control flow
    input  logic jump, branch, mispredict, ifence, fence_stall, serializer_stall,
    input  logic halt, ex_busy,
    // exceptions
    input  pipe_ctrl_pkg::exc_flags_t exc,
    input  pipe_ctrl_pkg::word_t badaddr,
    // stage pcs
    input  pipe_ctrl_pkg::word_t pc_f, pc_decode, pc_e, pc_m,
    input  logic valid_decode, valid_e, valid_m,
    input  logic ret, is_queue_full, queue_wen,
    // vector
    input  logic vsetvl_dec, vsetvl_ex, vbusy, vregwen,
    input  pipe_ctrl_pkg::vregidx_t vd, vs1, vs2,
    input  logic vs1_used, vs2_used, ex_mask_en,
    // pipeline controls
    output logic pc_en, npc_sel, insert_priv_pc,
    output pipe_ctrl_pkg::word_t priv_pc,
    output logic if_ex_stall, stall_queue, stall_decode, ex_mem_stall, vmask_calc_stall,
    output logic if_ex_flush, flush_queue, flush_decode, ex_mem_flush,
    output logic suppress_iren, suppress_data, rollback,
    // trap state
    output pipe_ctrl_pkg::word_t mepc_out,
    output pipe_ctrl_pkg::cause_t mcause_out,
    output logic mie_out
);

    hazard_unit_if hu_if ();
    prv_pipeline_if prv_if ();

    // stage inputs onto the hazard bus
    assign hu_if.rs1_e = rs1_e;
    assign hu_if.rs2_e = rs2_e;
    assign hu_if.rd_m = rd_m;
    assign hu_if.reg_write = reg_write;
    assign hu_if.dren = dren;
    assign hu_if.dwen = dwen;
    assign hu_if.csr_read = csr_read;
    assign hu_if.i_mem_busy = i_mem_busy;
    assign hu_if.d_mem_busy = d_mem_busy;
    assign hu_if.jump = jump;
    assign hu_if.branch = branch;
    assign hu_if.mispredict = mispredict;
    assign hu_if.ifence = ifence;
    assign hu_if.fence_stall = fence_stall;
    assign hu_if.serializer_stall = serializer_stall;
    assign hu_if.halt = halt;
    assign hu_if.ex_busy = ex_busy;
    assign hu_if.exc = exc;
    assign hu_if.badaddr = badaddr;
    assign hu_if.pc_f = pc_f;
    assign hu_if.pc_decode = pc_decode;
    assign hu_if.pc_e = pc_e;
    assign hu_if.pc_m = pc_m;
    assign hu_if.valid_decode = valid_decode;
    assign hu_if.valid_e = valid_e;
    assign hu_if.valid_m = valid_m;
    assign hu_if.ret = ret;
    assign hu_if.is_queue_full = is_queue_full;
    assign hu_if.queue_wen = queue_wen;
    assign hu_if.vsetvl_dec = vsetvl_dec;
    assign hu_if.vsetvl_ex = vsetvl_ex;
    assign hu_if.vbusy = vbusy;
    assign hu_if.vregwen = vregwen;
    assign hu_if.vd = vd;
    assign hu_if.vs1 = vs1;
    assign hu_if.vs2 = vs2;
    assign hu_if.vs1_used = vs1_used;
    assign hu_if.vs2_used = vs2_used;
    assign hu_if.ex_mask_en = ex_mask_en;

    // controls back out
    assign pc_en = hu_if.pc_en;
    assign npc_sel = hu_if.npc_sel;
    assign insert_priv_pc = hu_if.insert_priv_pc;
    assign priv_pc = hu_if.priv_pc;
    assign if_ex_stall = hu_if.if_ex_stall;
    assign stall_queue = hu_if.stall_queue;
    assign stall_decode = hu_if.stall_decode;
    assign ex_mem_stall = hu_if.ex_mem_stall;
    assign vmask_calc_stall = hu_if.vmask_calc_stall;
    assign if_ex_flush = hu_if.if_ex_flush;
    assign flush_queue = hu_if.flush_queue;
    assign flush_decode = hu_if.flush_decode;
    assign ex_mem_flush = hu_if.ex_mem_flush;
    assign suppress_iren = hu_if.suppress_iren;
    assign suppress_data = hu_if.suppress_data;
    assign rollback = hu_if.rollback;

    hazard_unit u_hazard (
        .CLK       (CLK),
        .nRST      (nRST),
        .hazard_if (hu_if),
        .prv_if    (prv_if)
    );

    // data wait as seen by the trap unit, busy with an access pending
    priv_trap_unit u_priv (
        .CLK        (CLK),
        .nRST       (nRST),
        .prv_if     (prv_if),
        .irq        (irq),
        .wait_dmem  (d_mem_busy & (dren | dwen)),
        .mepc_out   (mepc_out),
        .mcause_out (mcause_out),
        .mie_out    (mie_out)
    );

endmodule

// ==== hdl/priv_trap_unit.sv ====
`timescale 1ns/10ps

module priv_trap_unit (
    input logic CLK,
    input logic nRST,
    prv_pipeline_if.priv prv_if,
    input logic irq,
    input logic wait_dmem,
    output pipe_ctrl_pkg::word_t mepc_out,
    output pipe_ctrl_pkg::cause_t mcause_out,
    output logic mie_out
);

    // machine csrs kept here
    pipe_ctrl_pkg::word_t mepc;
    pipe_ctrl_pkg::cause_t mcause;
    logic mie;

    logic exception;
    logic intr_pend;
    logic accept;                 // trap taken this cycle
    pipe_ctrl_pkg::cause_t cause; // cause of the trap being taken

    assign exception = |prv_if.exc;
    assign intr_pend = irq && mie; // masked while in handler
    assign prv_if.intr = intr_pend;

    // interrupt alone holds off while a data access is in flight
    assign accept = exception || (intr_pend && !wait_dmem);

    // fixed priority over the flags
    always_comb begin
        if (prv_if.exc.fault_insn)
            cause = pipe_ctrl_pkg::CAUSE_FAULT_INSN;
        else if (prv_if.exc.mal_insn)
            cause = pipe_ctrl_pkg::CAUSE_MAL_INSN;
        else if (prv_if.exc.illegal_insn)
            cause = pipe_ctrl_pkg::CAUSE_ILLEGAL;
        else if (prv_if.exc.breakpoint)
            cause = pipe_ctrl_pkg::CAUSE_BREAKPOINT;
        else if (prv_if.exc.fault_l)
            cause = pipe_ctrl_pkg::CAUSE_FAULT_L;
        else if (prv_if.exc.mal_l)
            cause = pipe_ctrl_pkg::CAUSE_MAL_L;
        else if (prv_if.exc.fault_s)
            cause = pipe_ctrl_pkg::CAUSE_FAULT_S;
        else if (prv_if.exc.mal_s)
            cause = pipe_ctrl_pkg::CAUSE_MAL_S;
        else if (prv_if.exc.env)
            cause = pipe_ctrl_pkg::CAUSE_ECALL;
        else
            cause = pipe_ctrl_pkg::CAUSE_INTR; // no flag, so interrupt
    end

    // redirect, trap wins over a simultaneous ret
    assign prv_if.insert_pc = accept || prv_if.ret;
    assign prv_if.priv_pc = accept ? pipe_ctrl_pkg::TRAP_VECTOR : mepc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mepc <= '0;
            mcause <= '0;
            mie <= 1'b1; // interrupts enabled out of reset
        end else if (accept) begin
            mepc <= prv_if.epc;
            mcause <= cause;
            mie <= 1'b0;
        end else if (prv_if.ret) begin
            mie <= 1'b1; // back from handler
        end
    end

    assign mepc_out = mepc;
    assign mcause_out = mcause;
    assign mie_out = mie;

endmodule

// ==== hdl/prv_pipeline_if.sv ====
`timescale 1ns/10ps

interface prv_pipeline_if;

    // pipeline side notifications
    pipe_ctrl_pkg::exc_flags_t exc; // raw exception flags
    logic ret;                      // mret reached the trap point
    pipe_ctrl_pkg::word_t epc;      // pc of oldest valid insn
    pipe_ctrl_pkg::word_t badaddr;  // faulting address
    logic wb_enable;                // an insn retires this cycle

    // privilege side answers
    logic intr;                     // enabled interrupt pending
    logic insert_pc;                // redirect fetch to priv_pc
    pipe_ctrl_pkg::word_t priv_pc;  // trap vector or mepc

    modport hazard (
        output exc,
        output ret,
        output epc,
        output badaddr,
        output wb_enable,
        input  intr,
        input  insert_pc,
        input  priv_pc
    );

    modport priv (
        input  exc,
        input  ret,
        input  epc,
        input  badaddr,
        input  wb_enable,
        output intr,
        output insert_pc,
        output priv_pc
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# build the pipeline-control testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module pipe_ctrl_tb -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vpipe_ctrl_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== test/pipe_ctrl_model.svh ====
`ifndef PIPE_CTRL_MODEL_SVH
`define PIPE_CTRL_MODEL_SVH

// load or csr result in mem, needed by execute
function automatic logic mem_use_hazard(
    input pipe_ctrl_pkg::regidx_t rs1,
    input pipe_ctrl_pkg::regidx_t rs2,
    input pipe_ctrl_pkg::regidx_t rd,
    input logic wr,
    input logic load,
    input logic csr
);
    logic hit;
    hit = (rd != 5'd0) && ((rs1 == rd) || (rs2 == rd)); // x0 is never a producer
    return wr && (load || csr) && hit;
endfunction

// jump always, branch only when guessed wrong
function automatic logic redirect_taken(input logic jmp, input logic br, input logic mis);
    return jmp || (br && mis);
endfunction

// raw on a used vector source, or masked op writing v0
function automatic logic vreg_conflict(
    input logic wen,
    input pipe_ctrl_pkg::vregidx_t d,
    input pipe_ctrl_pkg::vregidx_t s1,
    input pipe_ctrl_pkg::vregidx_t s2,
    input logic s1_used,
    input logic s2_used,
    input logic masked
);
    return wen && ((s1_used && d == s1) || (s2_used && d == s2) || (masked && d == 5'd0));
endfunction

// flag order decides, nothing set means interrupt
function automatic pipe_ctrl_pkg::cause_t trap_cause(input pipe_ctrl_pkg::exc_flags_t f);
    if (f.fault_insn) return pipe_ctrl_pkg::CAUSE_FAULT_INSN;
    if (f.mal_insn) return pipe_ctrl_pkg::CAUSE_MAL_INSN;
    if (f.illegal_insn) return pipe_ctrl_pkg::CAUSE_ILLEGAL;
    if (f.breakpoint) return pipe_ctrl_pkg::CAUSE_BREAKPOINT;
    if (f.fault_l) return pipe_ctrl_pkg::CAUSE_FAULT_L;
    if (f.mal_l) return pipe_ctrl_pkg::CAUSE_MAL_L;
    if (f.fault_s) return pipe_ctrl_pkg::CAUSE_FAULT_S;
    if (f.mal_s) return pipe_ctrl_pkg::CAUSE_MAL_S;
    if (f.env) return pipe_ctrl_pkg::CAUSE_ECALL;
    return pipe_ctrl_pkg::CAUSE_INTR;
endfunction

// oldest valid pc, mem insn finishes when an interrupt is taken
function automatic pipe_ctrl_pkg::word_t oldest_pc(
    input logic vm, input logic ve, input logic vdec, input logic intr_taken,
    input pipe_ctrl_pkg::word_t pm, input pipe_ctrl_pkg::word_t pe,
    input pipe_ctrl_pkg::word_t pdec, input pipe_ctrl_pkg::word_t pf
);
    if (vm && !intr_taken) return pm;
    if (ve) return pe;
    if (vdec) return pdec;
    return pf;
endfunction

// flush first, then vsetvl leaving execute, then a new vsetvl queued
function automatic logic next_vsetvl_flag(
    input logic cur, input logic flush, input logic vex, input logic wen, input logic vdec
);
    if (flush) return 1'b0;
    if (vex) return 1'b0;
    if (wen && vdec) return 1'b1;
    return cur;
endfunction

`endif

// ==== test/pipe_ctrl_tb.sv ====
`timescale 1ns/10ps

module pipe_ctrl_tb;

    `include "pipe_ctrl_model.svh"

    logic CLK, nRST, irq;
    pipe_ctrl_pkg::regidx_t rs1_e, rs2_e, rd_m;
    logic reg_write, dren, dwen, csr_read, i_mem_busy, d_mem_busy;
    logic jump, branch, mispredict, ifence, fence_stall, serializer_stall, halt, ex_busy;
    pipe_ctrl_pkg::exc_flags_t exc;
    pipe_ctrl_pkg::word_t badaddr, pc_f, pc_decode, pc_e, pc_m;
    logic valid_decode, valid_e, valid_m, ret, is_queue_full, queue_wen;
    logic vsetvl_dec, vsetvl_ex, vbusy, vregwen;
    pipe_ctrl_pkg::vregidx_t vd, vs1, vs2;
    logic vs1_used, vs2_used, ex_mask_en;
    logic pc_en, npc_sel, insert_priv_pc;
    pipe_ctrl_pkg::word_t priv_pc, mepc_out;
    logic if_ex_stall, stall_queue, stall_decode, ex_mem_stall, vmask_calc_stall;
    logic if_ex_flush, flush_queue, flush_decode, ex_mem_flush;
    logic suppress_iren, suppress_data, rollback, mie_out;
    pipe_ctrl_pkg::cause_t mcause_out;

    integer seed;
    int ctrl_errors, word_errors, cause_errors;

    // model state now and after the coming edge
    pipe_ctrl_pkg::word_t m_mepc, n_mepc;
    pipe_ctrl_pkg::cause_t m_mcause, n_mcause;
    logic m_mie, n_mie, m_vsetvl, n_vsetvl;

    pipe_ctrl_top uut (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1; // off the edge like other inputs
    end

    // true with the given odds in percent
    function automatic logic chance(input int pct);
        int roll;
        roll = int'({$random(seed)} % 100);
        return roll < pct;
    endfunction

    task automatic check_ctrl(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            ctrl_errors++;
            $display("ERROR %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input pipe_ctrl_pkg::word_t got, input pipe_ctrl_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            word_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cause(input pipe_ctrl_pkg::cause_t got,
                               input pipe_ctrl_pkg::cause_t exp, input string what);
        if (got !== exp) begin
            cause_errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        irq = 1'b0;
        rs1_e = '0;
        rs2_e = '0;
        rd_m = '0;
        reg_write = 1'b0;
        dren = 1'b0;
        dwen = 1'b0;
        csr_read = 1'b0;
        i_mem_busy = 1'b0;
        d_mem_busy = 1'b0;
        jump = 1'b0;
        branch = 1'b0;
        mispredict = 1'b0;
        ifence = 1'b0;
        fence_stall = 1'b0;
        serializer_stall = 1'b0;
        halt = 1'b0;
        ex_busy = 1'b0;
        exc = '0;
        badaddr = '0;
        pc_f = '0;
        pc_decode = '0;
        pc_e = '0;
        pc_m = '0;
        valid_decode = 1'b0;
        valid_e = 1'b0;
        valid_m = 1'b0;
        ret = 1'b0;
        is_queue_full = 1'b0;
        queue_wen = 1'b0;
        vsetvl_dec = 1'b0;
        vsetvl_ex = 1'b0;
        vbusy = 1'b0;
        vregwen = 1'b0;
        vd = '0;
        vs1 = '0;
        vs2 = '0;
        vs1_used = 1'b0;
        vs2_used = 1'b0;
        ex_mask_en = 1'b0;
    endtask

    task automatic drive_random();
        logic [8:0] flags;
        flags = 9'($random(seed));
        irq = chance(30);
        rs1_e = 5'({$random(seed)} % 4); // tiny index range so matches are common
        rs2_e = 5'({$random(seed)} % 4);
        rd_m = 5'({$random(seed)} % 4);
        reg_write = chance(60);
        dren = chance(30);
        dwen = chance(20);
        csr_read = chance(15);
        i_mem_busy = chance(25);
        d_mem_busy = chance(30);
        jump = chance(10);
        branch = chance(20);
        mispredict = chance(50);
        ifence = chance(5);
        fence_stall = chance(5);
        serializer_stall = chance(5);
        halt = chance(3);
        ex_busy = chance(10);
        if (chance(12))
            exc = flags; // sometimes several flags at once
        else
            exc = '0;
        badaddr = {$random(seed)};
        pc_f = {$random(seed)} & 32'hffff_fffc;
        pc_decode = {$random(seed)} & 32'hffff_fffc;
        pc_e = {$random(seed)} & 32'hffff_fffc;
        pc_m = {$random(seed)} & 32'hffff_fffc;
        valid_decode = chance(70);
        valid_e = chance(70);
        valid_m = chance(70);
        ret = chance(6);
        is_queue_full = chance(10);
        queue_wen = chance(50);
        vsetvl_dec = chance(15);
        vsetvl_ex = chance(10);
        vbusy = chance(10);
        vregwen = chance(40);
        vd = 5'({$random(seed)} % 4);
        vs1 = 5'({$random(seed)} % 4);
        vs2 = 5'({$random(seed)} % 4);
        vs1_used = chance(50);
        vs2_used = chance(50);
        ex_mask_en = chance(20);
    endtask

    // compare this cycle's outputs, then work out the model's next state
    task automatic check_cycle();
        logic exception, bj, data_wait, intr_pend, accept, flush_all, ordinary, stall_fe;
        logic mem_stall, fence_done;
        exception = |exc;
        bj = redirect_taken(jump, branch, mispredict);
        data_wait = d_mem_busy && (dren || dwen);
        intr_pend = irq && m_mie;
        accept = exception || (intr_pend && !data_wait);
        fence_done = ifence && !fence_stall; // refetch once the fence drains
        flush_all = accept || ret || fence_done || bj;
        ordinary = !bj && !accept && !ret && !ifence; // no redirect of any kind
        mem_stall = (data_wait && !exception) || fence_stall || serializer_stall || halt;

        check_ctrl(npc_sel, bj, "npc_sel");
        check_ctrl(ex_mem_stall, mem_stall, "ex_mem_stall");
        if (mem_stall) check_ctrl(ex_mem_flush, 1'b0, "ex_mem_flush during mem wait");
        else if (bj) check_ctrl(ex_mem_flush, 1'b1, "ex_mem_flush on redirect");
        if (mem_use_hazard(rs1_e, rs2_e, rd_m, reg_write, dren, csr_read))
            check_ctrl(stall_queue, 1'b1, "stall_queue on mem-use");
        if (vreg_conflict(vregwen, vd, vs1, vs2, vs1_used, vs2_used, ex_mask_en))
            check_ctrl(vmask_calc_stall, 1'b1, "vmask_calc_stall on vreg conflict");
        if (bj) begin
            check_ctrl(pc_en, 1'b1, "pc_en on redirect");
            check_ctrl(if_ex_flush, 1'b1, "if_ex_flush on redirect");
            check_ctrl(suppress_iren, 1'b1, "suppress_iren on redirect");
        end
        check_ctrl(flush_queue, flush_all, "flush_queue");
        check_ctrl(flush_decode, flush_all, "flush_decode");
        check_ctrl(rollback, fence_done, "rollback");
        if (ordinary) begin
            stall_fe = is_queue_full || m_vsetvl || fence_stall || vbusy;
            check_ctrl(if_ex_stall, stall_fe, "if_ex_stall");
            check_ctrl(pc_en, !(stall_fe || i_mem_busy), "pc_en");
        end
        if (i_mem_busy) check_ctrl(if_ex_flush, 1'b1, "if_ex_flush on busy fetch");
        if (m_vsetvl) check_ctrl(stall_decode, 1'b1, "stall_decode behind vsetvl");
        check_ctrl(suppress_data, exception, "suppress_data");
        check_ctrl(insert_priv_pc, accept || ret, "insert_priv_pc");
        if (accept) check_word(priv_pc, pipe_ctrl_pkg::TRAP_VECTOR, "priv_pc on trap");
        else if (ret) check_word(priv_pc, m_mepc, "priv_pc on ret");
        check_word(mepc_out, m_mepc, "mepc_out");
        check_cause(mcause_out, m_mcause, "mcause_out");
        check_ctrl(mie_out, m_mie, "mie_out");

        n_mepc = m_mepc;
        n_mcause = m_mcause;
        n_mie = m_mie;
        if (accept) begin
            n_mepc = oldest_pc(valid_m, valid_e, valid_decode, intr_pend && !exception,
                               pc_m, pc_e, pc_decode, pc_f);
            n_mcause = trap_cause(exc);
            n_mie = 1'b0;
        end else if (ret) begin
            n_mie = 1'b1;
        end
        n_vsetvl = next_vsetvl_flag(m_vsetvl, flush_all, vsetvl_ex, queue_wen, vsetvl_dec);
    endtask

    initial begin
        int waited;
        seed = 31;
        ctrl_errors = 0;
        word_errors = 0;
        cause_errors = 0;
        drive_idle();
        n_mepc = '0;  // reset values
        n_mcause = '0;
        n_mie = 1'b1;
        n_vsetvl = 1'b0;

        waited = 0;
        while (nRST !== 1'b1 && waited < 20) begin
            @(posedge CLK);
            waited++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was not released within 20 clock cycles");
            $display("Simulation finished: FAIL");
        end else begin
            for (int cyc = 0; cyc < 3000; cyc++) begin
                @(posedge CLK);
                m_mepc = n_mepc;
                m_mcause = n_mcause;
                m_mie = n_mie;
                m_vsetvl = n_vsetvl;
                #1;
                drive_random();
                #4; // mid cycle with all combinational paths settled
                check_cycle();
            end
            $display("errors: control %0d, word %0d, cause %0d, total %0d", ctrl_errors,
                     word_errors, cause_errors, ctrl_errors + word_errors + cause_errors);
            if (ctrl_errors + word_errors + cause_errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

endmodule
